// ==== Makefile ====
SRCS := $(wildcard logic/*.sv tests/*.sv)

run: obj_dir/Vmxu_tb
	@out="$$(./obj_dir/Vmxu_tb)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

obj_dir/Vmxu_tb: mxu_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module mxu_tb -f mxu_top.f

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== logic/acc_drain.sv ====
`default_nettype none

module acc_drain #(
    parameter int ARRAY_DIM = 4
) (
    input  wire logic                       clk_i,
    input  wire logic                       arst_n_i,
    input  wire mxu_pkg::acc_t              psum_i [ARRAY_DIM],
    input  wire logic                       res_rd_i,
    input  wire logic [mxu_pkg::BUF_AW-1:0] res_addr_i,
    output mxu_pkg::acc_t                   res_data_o [ARRAY_DIM],
    acc_wr_if.drain                         wr
);

    // stage s holds columns 0..s, column c enters at stage c
    mxu_pkg::acc_t sk_q  [ARRAY_DIM-1][ARRAY_DIM];
    mxu_pkg::acc_t al    [ARRAY_DIM];
    mxu_pkg::acc_t acc_q [2**mxu_pkg::BUF_AW][ARRAY_DIM];

    always_ff @(posedge clk_i) begin
        sk_q[0][0] <= psum_i[0];
        for (int s = 1; s < ARRAY_DIM - 1; s++) begin
            for (int c = 0; c < s; c++) begin
                sk_q[s][c] <= sk_q[s-1][c];
            end
            sk_q[s][s] <= psum_i[s];
        end
    end

    // last column needs no delay
    always_comb begin
        for (int c = 0; c < ARRAY_DIM - 1; c++) begin
            al[c] = sk_q[ARRAY_DIM-2][c];
        end
        al[ARRAY_DIM-1] = psum_i[ARRAY_DIM-1];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '{default: '0};
        end else if (wr.wr_en) begin
            for (int c = 0; c < ARRAY_DIM; c++) begin
                if (wr.add_mode) begin
                    acc_q[wr.wr_addr][c] <= acc_q[wr.wr_addr][c] + al[c];
                end else begin
                    acc_q[wr.wr_addr][c] <= al[c];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_rd_i) begin
            res_data_o <= acc_q[res_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/acc_wr_if.sv ====
`default_nettype none

interface acc_wr_if;

    logic                       wr_en;
    logic [mxu_pkg::BUF_AW-1:0] wr_addr;
    // level for the whole command
    logic                       add_mode;
    // final vector of the command
    logic                       last;

    modport ctrl (
        output wr_en,
        output wr_addr,
        output add_mode,
        output last
    );

    modport drain (
        input wr_en,
        input wr_addr,
        input add_mode
    );

endinterface

`default_nettype wire

// ==== logic/act_feeder.sv ====
`default_nettype none

module act_feeder #(
    parameter int ARRAY_DIM = 4
) (
    input  wire logic                       clk_i,
    input  wire logic                       arst_n_i,
    input  wire logic                       act_we_i,
    input  wire logic [mxu_pkg::BUF_AW-1:0] act_addr_i,
    input  wire mxu_pkg::act_t              act_wdata_i [ARRAY_DIM],
    input  wire logic                       rd_en_i,
    input  wire logic [mxu_pkg::BUF_AW-1:0] rd_addr_i,
    output mxu_pkg::act_t                   act_o [ARRAY_DIM]
);

    mxu_pkg::act_t buf_q   [2**mxu_pkg::BUF_AW][ARRAY_DIM];
    mxu_pkg::act_t rdata_q [ARRAY_DIM];

    always_ff @(posedge clk_i) begin
        if (act_we_i) begin
            buf_q[act_addr_i] <= act_wdata_i;
        end
    end

    // idle cycles push zeros into the array
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '{default: '0};
        end else if (rd_en_i) begin
            rdata_q <= buf_q[rd_addr_i];
        end else begin
            rdata_q <= '{default: '0};
        end
    end

    // row r lags by r cycles
    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        if (r == 0) begin : g_direct
            assign act_o[r] = rdata_q[r];
        end else begin : g_skew
            mxu_pkg::act_t dly_q [r];

            always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    dly_q <= '{default: '0};
                end else begin
                    dly_q[0] <= rdata_q[r];
                    for (int k = 1; k < r; k++) begin
                        dly_q[k] <= dly_q[k-1];
                    end
                end
            end

            assign act_o[r] = dly_q[r-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mac_column.sv ====
`default_nettype none

module mac_column #(
    parameter int ARRAY_DIM = 4
) (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      w_we_i,
    input  wire logic [mxu_pkg::ROW_W-1:0] w_row_i,
    input  wire mxu_pkg::act_t             w_data_i,
    input  wire mxu_pkg::act_t             act_i [ARRAY_DIM],
    output mxu_pkg::act_t                  act_o [ARRAY_DIM],
    output mxu_pkg::acc_t                  psum_o
);

    mxu_pkg::act_t w_q    [ARRAY_DIM];
    mxu_pkg::acc_t psum_q [ARRAY_DIM];
    mxu_pkg::acc_t sum    [ARRAY_DIM];

    // stationary weights, one per row
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            w_q <= '{default: '0};
        end else begin
            for (int r = 0; r < ARRAY_DIM; r++) begin
                if (w_we_i && (w_row_i == mxu_pkg::ROW_W'(r))) begin
                    w_q[r] <= w_data_i;
                end
            end
        end
    end

    // top cell starts from zero, others add the sum from above
    always_comb begin
        sum[0] = mxu_pkg::acc_t'(act_i[0]) * mxu_pkg::acc_t'(w_q[0]);
        for (int r = 1; r < ARRAY_DIM; r++) begin
            sum[r] = psum_q[r-1] + mxu_pkg::acc_t'(act_i[r]) * mxu_pkg::acc_t'(w_q[r]);
        end
    end

    always_ff @(posedge clk_i) begin
        act_o  <= act_i;
        psum_q <= sum;
    end

    assign psum_o = psum_q[ARRAY_DIM-1];

endmodule

`default_nettype wire

// ==== logic/mxu_ctrl.sv ====
`default_nettype none

module mxu_ctrl #(
    parameter int ARRAY_DIM = 4
) (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  cmd_valid_i,
    input  wire mxu_pkg::mxu_cmd_u     cmd_i,
    output logic                       w_we_o,
    output logic [mxu_pkg::ROW_W-1:0]  w_row_o,
    output logic                       rd_en_o,
    output logic [mxu_pkg::BUF_AW-1:0] rd_addr_o,
    output logic                       busy_o,
    output logic                       done_o,
    acc_wr_if.ctrl                     wr
);

    // read, skew, column output, de-skew
    localparam int DEPTH   = 2 * ARRAY_DIM;
    localparam int FLUSH_W = $clog2(DEPTH + 1);

    localparam logic IDLE = 1'b0;
    localparam logic RUN  = 1'b1;

    logic                       state_q;
    logic                       start;
    logic [3:0]                 rows_left_q;
    logic [FLUSH_W-1:0]         flush_q;
    logic [mxu_pkg::BUF_AW-1:0] acc_addr_q;
    logic                       add_mode_q;
    logic [DEPTH-1:0]           en_pipe_q;
    logic [DEPTH-1:0]           last_pipe_q;
    logic [mxu_pkg::BUF_AW-1:0] addr_pipe_q [DEPTH];

    assign busy_o = (state_q == RUN);
    assign start  = cmd_valid_i && !busy_o && (cmd_i.compute.op == mxu_pkg::OP_COMPUTE);

    // weight rows bypass the fsm
    assign w_we_o  = cmd_valid_i && !busy_o && (cmd_i.wload.op == mxu_pkg::OP_WLOAD);
    assign w_row_o = cmd_i.wload.row;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            rd_en_o     <= 1'b0;
            rd_addr_o   <= '0;
            acc_addr_q  <= '0;
            rows_left_q <= '0;
            flush_q     <= '0;
            add_mode_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q     <= RUN;
                        rd_en_o     <= 1'b1;
                        rd_addr_o   <= cmd_i.compute.act_base;
                        acc_addr_q  <= cmd_i.compute.acc_base;
                        rows_left_q <= cmd_i.compute.rows_m1;
                        flush_q     <= FLUSH_W'(DEPTH);
                        add_mode_q  <= cmd_i.compute.accumulate;
                    end
                end
                default: begin
                    if (rd_en_o) begin
                        if (rows_left_q == '0) begin
                            rd_en_o <= 1'b0;
                        end else begin
                            rows_left_q <= rows_left_q - 1'b1;
                        end
                        rd_addr_o  <= rd_addr_o + 1'b1;
                        acc_addr_q <= acc_addr_q + 1'b1;
                    end else if (flush_q == '0) begin
                        state_q <= IDLE;
                    end else begin
                        // wait for the pipeline to drain
                        flush_q <= flush_q - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_pipe_q   <= '0;
            last_pipe_q <= '0;
            done_o      <= 1'b0;
        end else begin
            en_pipe_q   <= {en_pipe_q[DEPTH-2:0], rd_en_o};
            last_pipe_q <= {last_pipe_q[DEPTH-2:0], rd_en_o && (rows_left_q == '0)};
            done_o      <= wr.wr_en && wr.last;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_pipe_q[0] <= acc_addr_q;
        for (int i = 1; i < DEPTH; i++) begin
            addr_pipe_q[i] <= addr_pipe_q[i-1];
        end
    end

    assign wr.wr_en    = en_pipe_q[DEPTH-1];
    assign wr.last     = last_pipe_q[DEPTH-1];
    assign wr.wr_addr  = addr_pipe_q[DEPTH-1];
    assign wr.add_mode = add_mode_q;

endmodule

`default_nettype wire

// ==== logic/mxu_pkg.sv ====
`default_nettype none

package mxu_pkg;

    localparam int BUF_AW = 4;
    localparam int ROW_W  = 4;

    // code 2'b11 is left unnamed and decodes as a nop
    typedef enum logic [1:0] {
        OP_NOP     = 2'b00,
        OP_WLOAD   = 2'b01,
        OP_COMPUTE = 2'b10
    } mxu_op_e;

    typedef logic signed [7:0]  act_t;
    typedef logic signed [23:0] acc_t;

    typedef struct packed {
        mxu_op_e          op;
        logic [ROW_W-1:0] row;
        logic [9:0]       spare;
    } wload_cmd_t;

    typedef struct packed {
        mxu_op_e           op;
        logic              accumulate;
        logic [3:0]        rows_m1;
        logic [BUF_AW-1:0] act_base;
        logic [BUF_AW-1:0] acc_base;
        logic              spare;
    } compute_cmd_t;

    // op occupies the top two bits in both views
    typedef union packed {
        wload_cmd_t   wload;
        compute_cmd_t compute;
    } mxu_cmd_u;

endpackage

`default_nettype wire

// ==== logic/mxu_top.sv ====
`default_nettype none

module mxu_top #(
    parameter int ARRAY_DIM = 4
) (
    input  wire logic                       clk_i,
    input  wire logic                       arst_n_i,
    input  wire logic                       cmd_valid_i,
    input  wire mxu_pkg::mxu_cmd_u          cmd_i,
    input  wire mxu_pkg::act_t              wdata_i [ARRAY_DIM],
    input  wire logic                       act_we_i,
    input  wire logic [mxu_pkg::BUF_AW-1:0] act_addr_i,
    input  wire mxu_pkg::act_t              act_wdata_i [ARRAY_DIM],
    input  wire logic                       res_rd_i,
    input  wire logic [mxu_pkg::BUF_AW-1:0] res_addr_i,
    output mxu_pkg::acc_t                   res_data_o [ARRAY_DIM],
    output logic                            busy_o,
    output logic                            done_o
);

    logic                       w_we;
    logic [mxu_pkg::ROW_W-1:0]  w_row;
    logic                       rd_en;
    logic [mxu_pkg::BUF_AW-1:0] rd_addr;
    // activations travel right, entry c feeds column c
    mxu_pkg::act_t              act_bus [ARRAY_DIM+1][ARRAY_DIM];
    mxu_pkg::acc_t              psum    [ARRAY_DIM];

    acc_wr_if wr_if ();

    mxu_ctrl #(.ARRAY_DIM(ARRAY_DIM)) u_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .w_we_o      (w_we),
        .w_row_o     (w_row),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .wr          (wr_if.ctrl)
    );

    act_feeder #(.ARRAY_DIM(ARRAY_DIM)) u_feeder (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .act_we_i    (act_we_i),
        .act_addr_i  (act_addr_i),
        .act_wdata_i (act_wdata_i),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .act_o       (act_bus[0])
    );

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
        mac_column #(.ARRAY_DIM(ARRAY_DIM)) u_col (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .w_we_i   (w_we),
            .w_row_i  (w_row),
            .w_data_i (wdata_i[c]),
            .act_i    (act_bus[c]),
            .act_o    (act_bus[c+1]),
            .psum_o   (psum[c])
        );
    end

    acc_drain #(.ARRAY_DIM(ARRAY_DIM)) u_drain (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .psum_i     (psum),
        .res_rd_i   (res_rd_i),
        .res_addr_i (res_addr_i),
        .res_data_o (res_data_o),
        .wr         (wr_if.drain)
    );

endmodule

`default_nettype wire

// ==== mxu_top.f ====
logic/mxu_pkg.sv
logic/acc_wr_if.sv
logic/mxu_ctrl.sv
logic/act_feeder.sv
logic/mac_column.sv
logic/acc_drain.sv
logic/mxu_top.sv
tests/mxu_chk.sv
tests/mxu_tb.sv

// ==== tests/mxu_chk.sv ====
`default_nettype none

module mxu_chk (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic busy_i,
    input wire logic done_i,
    input wire logic rd_en_i,
    input wire logic wr_en_i,
    input wire logic wr_last_i
);

    int assert_fails = 0;

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_i |=> !done_i)
    else begin
        assert_fails++;
        $error("done_o stayed high for more than one cycle");
    end

    a_done_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_i |-> busy_i)
    else begin
        assert_fails++;
        $error("done_o high while busy_o is low");
    end

    // last flags the final write of a command
    a_last_final: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_en_i && wr_last_i |=> !wr_en_i)
    else begin
        assert_fails++;
        $error("accumulator write after the one flagged as last");
    end

    a_read_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_en_i |-> busy_i)
    else begin
        assert_fails++;
        $error("buffer read issued while busy_o is low");
    end

endmodule

bind mxu_ctrl mxu_chk u_chk (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .rd_en_i   (rd_en_o),
    .wr_en_i   (wr.wr_en),
    .wr_last_i (wr.last)
);

`default_nettype wire

// ==== tests/mxu_tb.sv ====
`default_nettype none

module mxu_tb;

    localparam int ARRAY_DIM = 4;
    localparam int PERIOD    = 100;
    // rows and command count over all tests
    localparam int TOTAL_M   = 41;
    localparam int N_CMDS    = 7;
    localparam int TIMEOUT   = TOTAL_M + N_CMDS * (2 * ARRAY_DIM + 40) + 500;

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       cmd_valid_i;
    mxu_pkg::mxu_cmd_u          cmd_i;
    mxu_pkg::act_t              wdata_i [ARRAY_DIM];
    logic                       act_we_i;
    logic [mxu_pkg::BUF_AW-1:0] act_addr_i;
    mxu_pkg::act_t              act_wdata_i [ARRAY_DIM];
    logic                       res_rd_i;
    logic [mxu_pkg::BUF_AW-1:0] res_addr_i;
    mxu_pkg::acc_t              res_data_o [ARRAY_DIM];
    logic                       busy_o;
    logic                       done_o;

    // reference model state
    mxu_pkg::act_t              w_ref   [ARRAY_DIM][ARRAY_DIM];
    mxu_pkg::act_t              buf_ref [16][ARRAY_DIM];
    mxu_pkg::acc_t              acc_ref [16][ARRAY_DIM];
    int unsigned                lcg_state = 77;

    mxu_top #(.ARRAY_DIM(ARRAY_DIM)) dut0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .wdata_i     (wdata_i),
        .act_we_i    (act_we_i),
        .act_addr_i  (act_addr_i),
        .act_wdata_i (act_wdata_i),
        .res_rd_i    (res_rd_i),
        .res_addr_i  (res_addr_i),
        .res_data_o  (res_data_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        #(TIMEOUT * PERIOD);
        abort_run("timeout: the tests did not finish within the cycle budget");
    end

    // drive point and output sample point
    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    // elements in -15..15
    function automatic mxu_pkg::act_t lcg_elem();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return mxu_pkg::act_t'(int'((lcg_state >> 16) % 31) - 15);
    endfunction

    task automatic acc_matches(string name, mxu_pkg::acc_t got, mxu_pkg::acc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic bit_matches(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic count_matches(string name, int got, int exp);
        if (got != exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic load_weights();
        for (int r = 0; r < ARRAY_DIM; r++) begin
            for (int c = 0; c < ARRAY_DIM; c++) begin
                w_ref[r][c] = lcg_elem();
                wdata_i[c]  = w_ref[r][c];
            end
            cmd_i            = '0;
            cmd_i.wload.op   = mxu_pkg::OP_WLOAD;
            cmd_i.wload.row  = mxu_pkg::ROW_W'(r);
            cmd_valid_i      = 1'b1;
            next_cycle();
        end
        cmd_valid_i = 1'b0;
    endtask

    task automatic write_acts(int base, int m);
        int addr;
        for (int i = 0; i < m; i++) begin
            addr = (base + i) % 16;
            for (int r = 0; r < ARRAY_DIM; r++) begin
                buf_ref[addr][r] = lcg_elem();
                act_wdata_i[r]   = buf_ref[addr][r];
            end
            act_addr_i = mxu_pkg::BUF_AW'(addr);
            act_we_i   = 1'b1;
            next_cycle();
        end
        act_we_i = 1'b0;
    endtask

    task automatic issue_compute(int act_base, int acc_base, int m, bit accum);
        cmd_i                    = '0;
        cmd_i.compute.op         = mxu_pkg::OP_COMPUTE;
        cmd_i.compute.accumulate = accum;
        cmd_i.compute.rows_m1    = 4'(m - 1);
        cmd_i.compute.act_base   = mxu_pkg::BUF_AW'(act_base);
        cmd_i.compute.acc_base   = mxu_pkg::BUF_AW'(acc_base);
        cmd_valid_i              = 1'b1;
        next_cycle();
        cmd_valid_i = 1'b0;
    endtask

    // elapsed counts edges since the command was driven
    task automatic await_done(int m, int elapsed);
        int cycles;
        cycles = elapsed;
        while (done_o !== 1'b1) begin
            bit_matches("busy_o", busy_o, 1'b1);
            if (cycles >= m + 2 * ARRAY_DIM + 40) begin
                abort_run("timeout: done_o never pulsed after a compute command");
            end else begin
                next_cycle();
                cycles++;
            end
        end
        bit_matches("busy_o", busy_o, 1'b1);
        count_matches("done_o latency", cycles, m + 2 * ARRAY_DIM + 1);
        next_cycle();
        bit_matches("done_o", done_o, 1'b0);
        bit_matches("busy_o", busy_o, 1'b0);
    endtask

    function automatic void update_model(int act_base, int acc_base, int m, bit accum);
        int            a_addr;
        int            r_addr;
        mxu_pkg::acc_t sum;
        for (int i = 0; i < m; i++) begin
            a_addr = (act_base + i) % 16;
            r_addr = (acc_base + i) % 16;
            for (int c = 0; c < ARRAY_DIM; c++) begin
                sum = '0;
                for (int r = 0; r < ARRAY_DIM; r++) begin
                    sum = sum + mxu_pkg::acc_t'(int'(buf_ref[a_addr][r]) * int'(w_ref[r][c]));
                end
                acc_ref[r_addr][c] = accum ? acc_ref[r_addr][c] + sum : sum;
            end
        end
    endfunction

    task automatic compute_and_wait(int act_base, int acc_base, int m, bit accum);
        bit_matches("busy_o", busy_o, 1'b0);
        issue_compute(act_base, acc_base, m, accum);
        await_done(m, 1);
        update_model(act_base, acc_base, m, accum);
    endtask

    // one address per cycle, data shows up on the next edge
    task automatic verify_acc_image();
        for (int a = 0; a < 16; a++) begin
            res_addr_i = mxu_pkg::BUF_AW'(a);
            res_rd_i   = 1'b1;
            next_cycle();
            for (int c = 0; c < ARRAY_DIM; c++) begin
                acc_matches($sformatf("res_data_o[%0d] at entry %0d", c, a),
                            res_data_o[c], acc_ref[a][c]);
            end
        end
        res_rd_i = 1'b0;
    endtask

    task automatic reset_values();
        bit_matches("busy_o", busy_o, 1'b0);
        bit_matches("done_o", done_o, 1'b0);
        verify_acc_image();
    endtask

    task automatic overwrite_product();
        load_weights();
        write_acts(0, 4);
        compute_and_wait(0, 0, 4, 1'b0);
        verify_acc_image();
    endtask

    task automatic accumulate_product();
        write_acts(4, 4);
        compute_and_wait(4, 0, 4, 1'b1);
        verify_acc_image();
    endtask

    task automatic command_timing();
        write_acts(0, 1);
        compute_and_wait(0, 5, 1, 1'b0);
        verify_acc_image();
        write_acts(0, 16);
        compute_and_wait(0, 0, 16, 1'b0);
        verify_acc_image();
    endtask

    task automatic address_wraparound();
        write_acts(12, 6);
        compute_and_wait(12, 14, 6, 1'b0);
        verify_acc_image();
    endtask

    task automatic busy_commands_ignored();
        write_acts(0, 8);
        issue_compute(0, 8, 8, 1'b0);
        // second compute while busy
        bit_matches("busy_o", busy_o, 1'b1);
        cmd_i                    = '0;
        cmd_i.compute.op         = mxu_pkg::OP_COMPUTE;
        cmd_i.compute.accumulate = 1'b1;
        cmd_i.compute.rows_m1    = 4'd1;
        cmd_i.compute.act_base   = 4'd3;
        cmd_valid_i              = 1'b1;
        next_cycle();
        // weight row 0 load while busy, data differs from the model
        bit_matches("busy_o", busy_o, 1'b1);
        for (int c = 0; c < ARRAY_DIM; c++) begin
            wdata_i[c] = w_ref[0][c] + 8'sd1;
        end
        cmd_i           = '0;
        cmd_i.wload.op  = mxu_pkg::OP_WLOAD;
        next_cycle();
        cmd_valid_i = 1'b0;
        await_done(8, 3);
        update_model(0, 8, 8, 1'b0);
        write_acts(8, 2);
        compute_and_wait(8, 12, 2, 1'b0);
        verify_acc_image();
    endtask

    initial begin
        arst_n_i    = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        wdata_i     = '{default: '0};
        act_we_i    = 1'b0;
        act_addr_i  = '0;
        act_wdata_i = '{default: '0};
        res_rd_i    = 1'b0;
        res_addr_i  = '0;
        w_ref       = '{default: '0};
        buf_ref     = '{default: '0};
        acc_ref     = '{default: '0};
        repeat (5) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;
        next_cycle();

        reset_values();
        overwrite_product();
        accumulate_product();
        command_timing();
        address_wraparound();
        busy_commands_ignored();

        if (dut0.u_ctrl.u_chk.assert_fails != 0) begin
            abort_run("controller assertions reported failures");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
